/* logic/rv_operand_macros.svh */
`ifndef RV_OPERAND_MACROS_SVH
`define RV_OPERAND_MACROS_SVH

// Integer register width
`define RV_XLEN 32

// Register index width and number of architectural registers
`define RV_REG_W 5
`define RV_REG_N 32

// Load data timing of the data memory when nothing else is chosen
`define RV_MEM_TYPE_DEFAULT rv_operand_pkg::MEM_TYPE_SRAM

`endif

/* logic/rv_operand_pkg.sv */
package rv_operand_pkg;

  // Where the result of an instruction in a later stage comes from
  typedef enum logic [2:0] {
    // Integer ALU
    RES_ALU = 3'd0,
    // Load data from data memory
    RES_MEM = 3'd1,
    // CSR read value
    RES_CSR = 3'd2,
    // Two-stage multiplier whose result is valid only in WB
    RES_M   = 3'd3,
    // Return address for JAL and JALR
    RES_PC4 = 3'd4
  } res_src_t;

  // Data memory styles
  // SRAM returns load data during MEM
  localparam int MEM_TYPE_SRAM = 0;

  // BRAM registers load data, so it is first seen in WB
  localparam int MEM_TYPE_BRAM = 1;

endpackage

/* logic/rv_regfile.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,

  // Two read ports used by the ID stage
  input  logic [`RV_REG_W-1:0] raddr1,
  input  logic [`RV_REG_W-1:0] raddr2,
  output logic [`RV_XLEN-1:0]  rdata1,
  output logic [`RV_XLEN-1:0]  rdata2,

  // Write port driven from WB
  input  logic                we,
  input  logic [`RV_REG_W-1:0] waddr,
  input  logic [`RV_XLEN-1:0]  wdata
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_REG_N-1];

  logic wr_en;

  assign wr_en = we && (waddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  // A same-cycle write is covered by WB forwarding
  always_comb begin
    if (raddr1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == '0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

  // An unknown write address would corrupt an arbitrary register
  a_wr_ctrl_known: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(we) && (!we || !$isunknown(waddr))
  ) else $error("rv_regfile: unknown write enable or address");

endmodule

/* logic/rv_fwd_id.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module rv_fwd_id #(
  parameter int MEM_TYPE = `RV_MEM_TYPE_DEFAULT
) (
  // ID sources and register file data
  input  logic [`RV_REG_W-1:0]      rs1_id,
  input  logic [`RV_REG_W-1:0]      rs2_id,
  input  logic [`RV_XLEN-1:0]       rs1_data_id,
  input  logic [`RV_XLEN-1:0]       rs2_data_id,

  // MEM producer
  input  logic [`RV_REG_W-1:0]      rd_mem,
  input  logic                     reg_write_mem,
  input  rv_operand_pkg::res_src_t res_src_mem,
  input  logic [`RV_XLEN-1:0]       result_mem,
  input  logic [`RV_XLEN-1:0]       load_data_mem,

  // WB writer
  input  logic [`RV_REG_W-1:0]      rd_wb,
  input  logic                     reg_write_wb,
  input  logic [`RV_XLEN-1:0]       rd_data_wb,

  // Operands handed to ID/EX
  output logic [`RV_XLEN-1:0]       fwd_rs1_id,
  output logic [`RV_XLEN-1:0]       fwd_rs2_id
);

  // Load data can only be forwarded when memory answers within MEM
  localparam bit LOAD_FWD = (MEM_TYPE == rv_operand_pkg::MEM_TYPE_SRAM);

  logic is_load_mem;
  logic late_src_mem;
  logic mem_active;
  logic wb_active;

  logic load_hit_rs1;
  logic load_hit_rs2;
  logic alu_hit_rs1;
  logic alu_hit_rs2;
  logic wb_hit_rs1;
  logic wb_hit_rs2;

  // Priority select shared by both operands
  function automatic logic [`RV_XLEN-1:0] pick_operand(
    input logic                load_hit,
    input logic                alu_hit,
    input logic                wb_hit,
    input logic [`RV_XLEN-1:0]  rf_data
  );
    if (LOAD_FWD && load_hit) begin
      return load_data_mem;
    end else if (alu_hit) begin
      return result_mem;
    end else if (wb_hit) begin
      return rd_data_wb;
    end
    return rf_data;
  endfunction

  assign is_load_mem = (res_src_mem == rv_operand_pkg::RES_MEM);

  // CSR and multiply results are not settled until WB
  assign late_src_mem = is_load_mem ||
                        (res_src_mem == rv_operand_pkg::RES_CSR) ||
                        (res_src_mem == rv_operand_pkg::RES_M);

  assign mem_active = reg_write_mem && (rd_mem != '0);
  assign wb_active  = reg_write_wb && (rd_wb != '0);

  // Source matches per producer
  assign load_hit_rs1 = mem_active && is_load_mem && (rd_mem == rs1_id);
  assign load_hit_rs2 = mem_active && is_load_mem && (rd_mem == rs2_id);
  assign alu_hit_rs1  = mem_active && !late_src_mem && (rd_mem == rs1_id);
  assign alu_hit_rs2  = mem_active && !late_src_mem && (rd_mem == rs2_id);
  assign wb_hit_rs1   = wb_active && (rd_wb == rs1_id);
  assign wb_hit_rs2   = wb_active && (rd_wb == rs2_id);

  assign fwd_rs1_id = pick_operand(load_hit_rs1, alu_hit_rs1, wb_hit_rs1, rs1_data_id);
  assign fwd_rs2_id = pick_operand(load_hit_rs2, alu_hit_rs2, wb_hit_rs2, rs2_data_id);

  // Encodings above RES_PC4 would pass as ALU results
  a_legal_res_src: assert final (
    !reg_write_mem || (res_src_mem <= rv_operand_pkg::RES_PC4)
  ) else $error("rv_fwd_id: illegal res_src_mem encoding");

endmodule

/* logic/rv_hazard_id.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module rv_hazard_id #(
  parameter int MEM_TYPE = `RV_MEM_TYPE_DEFAULT
) (
  // Instruction in ID
  input  logic [`RV_REG_W-1:0]      rs1_id,
  input  logic [`RV_REG_W-1:0]      rs2_id,
  input  logic                     valid_id,

  // Producer in MEM
  input  logic [`RV_REG_W-1:0]      rd_mem,
  input  logic                     reg_write_mem,
  input  rv_operand_pkg::res_src_t res_src_mem,

  // Hold fetch and decode, bubble into EX
  output logic                     stall_id
);

  localparam bit LOAD_LATE = (MEM_TYPE == rv_operand_pkg::MEM_TYPE_BRAM);

  if ((MEM_TYPE != rv_operand_pkg::MEM_TYPE_SRAM) &&
      (MEM_TYPE != rv_operand_pkg::MEM_TYPE_BRAM)) begin : g_bad_mem_type
    $error("rv_hazard_id: unsupported MEM_TYPE %0d", MEM_TYPE);
  end

  logic is_load_mem;
  logic is_csr_mem;
  logic is_m_mem;
  logic late_src_mem;
  logic src_match;

  assign is_load_mem = (res_src_mem == rv_operand_pkg::RES_MEM);
  assign is_csr_mem  = (res_src_mem == rv_operand_pkg::RES_CSR);
  assign is_m_mem    = (res_src_mem == rv_operand_pkg::RES_M);

  // Value only exists once the producer reaches WB
  assign late_src_mem = is_csr_mem || is_m_mem || (LOAD_LATE && is_load_mem);

  // x0 never creates a dependency
  assign src_match = (rd_mem != '0) && ((rd_mem == rs1_id) || (rd_mem == rs2_id));

  assign stall_id = valid_id && reg_write_mem && late_src_mem && src_match;

  // Fetch and decode act on this level every cycle
  a_stall_known: assert final (
    !$isunknown(stall_id)
  ) else $error("rv_hazard_id: stall_id is unknown");

endmodule

/* logic/rv_idex_reg.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module rv_idex_reg (
  input  logic               clk,
  input  logic               rst,

  // From ID
  input  logic               valid_id,
  input  logic               stall_id,
  input  logic [`RV_XLEN-1:0] fwd_rs1_id,
  input  logic [`RV_XLEN-1:0] fwd_rs2_id,

  // To EX
  output logic               valid_ex,
  output logic [`RV_XLEN-1:0] rs1_ex,
  output logic [`RV_XLEN-1:0] rs2_ex
);

  logic capture;

  // Stall turns the ID slot into a bubble
  assign capture = valid_id && !stall_id;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_ex <= 1'b0;
    end else begin
      valid_ex <= capture;
    end
  end

  // Operands hold their last value across bubbles
  always_ff @(posedge clk) begin
    if (capture) begin
      rs1_ex <= fwd_rs1_id;
      rs2_ex <= fwd_rs2_id;
    end
  end

  // Fetch and decode keep a stalled instruction in ID
  a_stall_holds_id: assert property (
    @(posedge clk) disable iff (rst)
    (valid_id && stall_id) |=> valid_id
  ) else $error("rv_idex_reg: instruction left ID during a stall");

endmodule

/* logic/rv_operand_stage.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module rv_operand_stage #(
  parameter int MEM_TYPE = `RV_MEM_TYPE_DEFAULT
) (
  input  logic                     clk,
  input  logic                     rst,

  // ID sources
  input  logic [`RV_REG_W-1:0]      rs1_id,
  input  logic [`RV_REG_W-1:0]      rs2_id,
  input  logic                     valid_id,

  // MEM producer
  input  logic [`RV_REG_W-1:0]      rd_mem,
  input  logic                     reg_write_mem,
  input  rv_operand_pkg::res_src_t res_src_mem,
  input  logic [`RV_XLEN-1:0]       result_mem,
  input  logic [`RV_XLEN-1:0]       load_data_mem,

  // WB writer
  input  logic [`RV_REG_W-1:0]      rd_wb,
  input  logic                     reg_write_wb,
  input  logic [`RV_XLEN-1:0]       rd_data_wb,

  // EX operands and upstream hold
  output logic [`RV_XLEN-1:0]       rs1_ex,
  output logic [`RV_XLEN-1:0]       rs2_ex,
  output logic                     valid_ex,
  output logic                     stall_id
);

  logic [`RV_XLEN-1:0] rs1_data_id;
  logic [`RV_XLEN-1:0] rs2_data_id;
  logic [`RV_XLEN-1:0] fwd_rs1_id;
  logic [`RV_XLEN-1:0] fwd_rs2_id;

  rv_regfile u_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1_id),
    .raddr2 (rs2_id),
    .rdata1 (rs1_data_id),
    .rdata2 (rs2_data_id),
    .we     (reg_write_wb),
    .waddr  (rd_wb),
    .wdata  (rd_data_wb)
  );

  rv_fwd_id #(
    .MEM_TYPE (MEM_TYPE)
  ) u_fwd_id (
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .rs1_data_id   (rs1_data_id),
    .rs2_data_id   (rs2_data_id),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .res_src_mem   (res_src_mem),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .rd_wb         (rd_wb),
    .reg_write_wb  (reg_write_wb),
    .rd_data_wb    (rd_data_wb),
    .fwd_rs1_id    (fwd_rs1_id),
    .fwd_rs2_id    (fwd_rs2_id)
  );

  rv_hazard_id #(
    .MEM_TYPE (MEM_TYPE)
  ) u_hazard_id (
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .valid_id      (valid_id),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .res_src_mem   (res_src_mem),
    .stall_id      (stall_id)
  );

  rv_idex_reg u_idex_reg (
    .clk        (clk),
    .rst        (rst),
    .valid_id   (valid_id),
    .stall_id   (stall_id),
    .fwd_rs1_id (fwd_rs1_id),
    .fwd_rs2_id (fwd_rs2_id),
    .valid_ex   (valid_ex),
    .rs1_ex     (rs1_ex),
    .rs2_ex     (rs2_ex)
  );

endmodule

/* test/tb_rv_operand_ref.svh */
`ifndef TB_RV_OPERAND_REF_SVH
`define TB_RV_OPERAND_REF_SVH

// Operand that ID hands to EX for source rs, given the register file value
function automatic logic [`RV_XLEN-1:0] expect_operand(
  input logic [`RV_REG_W-1:0] rs,
  input logic [`RV_XLEN-1:0]  rf_value
);
  logic mem_hit;
  logic wb_hit;
  logic is_load;
  logic late;
  mem_hit = reg_write_mem && (rd_mem != '0) && (rd_mem == rs);
  wb_hit  = reg_write_wb && (rd_wb != '0) && (rd_wb == rs);
  is_load = (res_src_mem == rv_operand_pkg::RES_MEM);
  late    = is_load || (res_src_mem == rv_operand_pkg::RES_CSR) ||
            (res_src_mem == rv_operand_pkg::RES_M);
  // Load data only exists in MEM with SRAM
  if (mem_hit && is_load && (MEM_TYPE == rv_operand_pkg::MEM_TYPE_SRAM)) begin
    return load_data_mem;
  end else if (mem_hit && !late) begin
    return result_mem;
  end else if (wb_hit) begin
    return rd_data_wb;
  end
  return rf_value;
endfunction

// MEM producer feeds a source but has no value yet
function automatic logic expect_stall();
  logic hit;
  logic late;
  hit  = (rd_mem != '0) && ((rd_mem == rs1_id) || (rd_mem == rs2_id));
  late = (res_src_mem == rv_operand_pkg::RES_CSR) ||
         (res_src_mem == rv_operand_pkg::RES_M) ||
         ((res_src_mem == rv_operand_pkg::RES_MEM) &&
          (MEM_TYPE == rv_operand_pkg::MEM_TYPE_BRAM));
  return valid_id && reg_write_mem && hit && late;
endfunction

`endif

/* test/tb_rv_operand.sv */
`timescale 1ns/1ps

`include "rv_operand_macros.svh"

module tb_rv_operand #(
  parameter int MEM_TYPE = `RV_MEM_TYPE_DEFAULT
);

  logic                     clk;
  logic                     rst;
  logic [`RV_REG_W-1:0]      rs1_id;
  logic [`RV_REG_W-1:0]      rs2_id;
  logic                     valid_id;
  logic [`RV_REG_W-1:0]      rd_mem;
  logic                     reg_write_mem;
  rv_operand_pkg::res_src_t res_src_mem;
  logic [`RV_XLEN-1:0]       result_mem;
  logic [`RV_XLEN-1:0]       load_data_mem;
  logic [`RV_REG_W-1:0]      rd_wb;
  logic                     reg_write_wb;
  logic [`RV_XLEN-1:0]       rd_data_wb;
  logic [`RV_XLEN-1:0]       rs1_ex;
  logic [`RV_XLEN-1:0]       rs2_ex;
  logic                     valid_ex;
  logic                     stall_id;

  // Shadow register file and predictions for the next edge
  logic [`RV_XLEN-1:0] shadow [0:`RV_REG_N-1];
  logic                have_prev;
  logic                have_ops;
  logic                exp_valid;
  logic                exp_stall;
  logic [`RV_XLEN-1:0] exp_rs1;
  logic [`RV_XLEN-1:0] exp_rs2;
  int                  errors;
  int                  checks;

  `include "tb_rv_operand_ref.svh"

  rv_operand_stage #(
    .MEM_TYPE (MEM_TYPE)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .valid_id      (valid_id),
    .rd_mem        (rd_mem),
    .reg_write_mem (reg_write_mem),
    .res_src_mem   (res_src_mem),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .rd_wb         (rd_wb),
    .reg_write_wb  (reg_write_wb),
    .rd_data_wb    (rd_data_wb),
    .rs1_ex        (rs1_ex),
    .rs2_ex        (rs2_ex),
    .valid_ex      (valid_ex),
    .stall_id      (stall_id)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Registered outputs are read before this edge updates them
  always @(posedge clk) begin
    if (have_prev) begin
      checks++;
      if (valid_ex !== exp_valid) begin
        errors++;
        $display("Fail valid_ex: got %h expected %h at %0t", valid_ex, exp_valid, $time);
      end
      // Operands are also held across bubbles
      if (have_ops && (rs1_ex !== exp_rs1)) begin
        errors++;
        $display("Fail rs1_ex: got %h expected %h at %0t", rs1_ex, exp_rs1, $time);
      end
      if (have_ops && (rs2_ex !== exp_rs2)) begin
        errors++;
        $display("Fail rs2_ex: got %h expected %h at %0t", rs2_ex, exp_rs2, $time);
      end
    end
    exp_stall = expect_stall();
    if (stall_id !== exp_stall) begin
      errors++;
      $display("Fail stall_id: got %h expected %h at %0t", stall_id, exp_stall, $time);
    end
    if (rst) begin
      for (int i = 0; i < `RV_REG_N; i++) begin
        shadow[i] = '0;
      end
      exp_valid = 1'b0;
    end else begin
      exp_valid = valid_id && !exp_stall;
      if (exp_valid) begin
        exp_rs1  = expect_operand(rs1_id, shadow[rs1_id]);
        exp_rs2  = expect_operand(rs2_id, shadow[rs2_id]);
        have_ops = 1'b1;
      end
      if (reg_write_wb && (rd_wb != '0)) begin
        shadow[rd_wb] = rd_data_wb;
      end
    end
    have_prev = 1'b1;
  end

  task automatic idle_inputs();
    rs1_id        = '0;
    rs2_id        = '0;
    valid_id      = 1'b0;
    rd_mem        = '0;
    reg_write_mem = 1'b0;
    res_src_mem   = rv_operand_pkg::RES_ALU;
    result_mem    = '0;
    load_data_mem = '0;
    rd_wb         = '0;
    reg_write_wb  = 1'b0;
    rd_data_wb    = '0;
  endtask

  task automatic set_id(input logic [`RV_REG_W-1:0] rs1, input logic [`RV_REG_W-1:0] rs2);
    rs1_id   = rs1;
    rs2_id   = rs2;
    valid_id = 1'b1;
  endtask

  task automatic set_mem(
    input logic [`RV_REG_W-1:0]      rd,
    input rv_operand_pkg::res_src_t src,
    input logic [`RV_XLEN-1:0]       result,
    input logic [`RV_XLEN-1:0]       load
  );
    rd_mem        = rd;
    reg_write_mem = 1'b1;
    res_src_mem   = src;
    result_mem    = result;
    load_data_mem = load;
  endtask

  task automatic set_wb(input logic [`RV_REG_W-1:0] rd, input logic [`RV_XLEN-1:0] data);
    rd_wb        = rd;
    reg_write_wb = 1'b1;
    rd_data_wb   = data;
  endtask

  // MEM producer moves on to WB with its final value
  task automatic advance_to_wb();
    rd_wb         = rd_mem;
    reg_write_wb  = reg_write_mem;
    rd_data_wb    = (res_src_mem == rv_operand_pkg::RES_MEM) ? load_data_mem : result_mem;
    rd_mem        = '0;
    reg_write_mem = 1'b0;
  endtask

  task automatic wait_stall(input logic level, input int max_cycles);
    int n;
    n = 0;
    #1;
    while ((stall_id !== level) && (n < max_cycles)) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (stall_id !== level) begin
      errors++;
      $display("Timeout: stall_id never reached %0b within %0d cycles", level, max_cycles);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  endtask

  // CSR or M result in MEM, then resolved from WB
  task automatic late_producer(input rv_operand_pkg::res_src_t src, input logic [`RV_XLEN-1:0] v);
    set_id(5'd4, 5'd12);
    set_mem(5'd12, src, v, ~v);
    wait_stall(1'b1, 4);
    @(negedge clk);
    advance_to_wb();
    wait_stall(1'b0, 4);
    @(negedge clk);
    idle_inputs();
  endtask

  // Small register range most of the time so producers hit often
  function automatic logic [`RV_REG_W-1:0] pick_reg();
    if ($urandom_range(0, 3) == 0) begin
      return $urandom_range(0, `RV_REG_N - 1);
    end
    return $urandom_range(0, 7);
  endfunction

  task automatic random_cycle();
    // Upstream holds ID while stalled
    if (stall_id !== 1'b1) begin
      valid_id = ($urandom_range(0, 7) != 0);
      rs1_id   = pick_reg();
      rs2_id   = pick_reg();
    end
    reg_write_mem = $urandom_range(0, 1);
    rd_mem        = pick_reg();
    res_src_mem   = rv_operand_pkg::res_src_t'($urandom_range(0, 4));
    result_mem    = $urandom();
    load_data_mem = $urandom();
    reg_write_wb  = $urandom_range(0, 1);
    rd_wb         = pick_reg();
    rd_data_wb    = $urandom();
  endtask

  initial begin
    void'($urandom(32'h623abd71));
    have_prev = 1'b0;
    have_ops  = 1'b0;
    errors    = 0;
    checks    = 0;
    rst       = 1'b1;
    idle_inputs();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    set_id(5'd3, 5'd7);
    @(negedge clk);
    idle_inputs();
    for (int r = 1; r < `RV_REG_N; r++) begin
      set_wb(r[`RV_REG_W-1:0], (r * 32'h0101_0101) ^ 32'hc3a5_0000);
      @(negedge clk);
    end
    idle_inputs();
    for (int r = 0; r < `RV_REG_N; r++) begin
      set_id(r[`RV_REG_W-1:0], 5'd31 - r[`RV_REG_W-1:0]);
      @(negedge clk);
    end
    // x0 ignores producers aimed at it
    set_id(5'd0, 5'd0);
    set_mem(5'd0, rv_operand_pkg::RES_ALU, 32'hdead_beef, 32'h1234_5678);
    set_wb(5'd0, 32'hcafe_f00d);
    @(negedge clk);
    idle_inputs();
    set_id(5'd5, 5'd0);
    set_wb(5'd5, 32'h1111_2222);
    @(negedge clk);
    set_id(5'd6, 5'd6);
    set_mem(5'd6, rv_operand_pkg::RES_ALU, 32'haaaa_5555, 32'h0);
    set_wb(5'd6, 32'h5555_aaaa);
    @(negedge clk);
    idle_inputs();
    set_id(5'd9, 5'd2);
    set_mem(5'd9, rv_operand_pkg::RES_MEM, 32'h0bad_f00d, 32'h600d_cafe);
    wait_stall(MEM_TYPE == rv_operand_pkg::MEM_TYPE_BRAM, 4);
    @(negedge clk);
    advance_to_wb();
    wait_stall(1'b0, 4);
    @(negedge clk);
    idle_inputs();
    late_producer(rv_operand_pkg::RES_CSR, 32'h0000_3c0f);
    late_producer(rv_operand_pkg::RES_M, 32'h7654_3210);
    for (int n = 0; n < 500; n++) begin
      @(negedge clk);
      random_cycle();
    end
    @(negedge clk);
    // A stalled instruction leaves ID once the MEM producer is gone
    reg_write_mem = 1'b0;
    @(negedge clk);
    idle_inputs();
    repeat (2) @(negedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* rv_operand.f */
+incdir+logic
+incdir+test
logic/rv_operand_pkg.sv
logic/rv_regfile.sv
logic/rv_fwd_id.sv
logic/rv_hazard_id.sv
logic/rv_idex_reg.sv
logic/rv_operand_stage.sv
test/tb_rv_operand.sv
